// File: compile.f
hdl/cu_bus_pkg.sv
hdl/cu_arbiter_cfg_pkg.sv
hdl/cu_command_capture.sv
hdl/command_rr_arbiter.sv
hdl/command_burst_fifo.sv
hdl/response_router.sv
hdl/done_count_reduce.sv
hdl/cu_arbiter_control.sv
sim/tb_cu_arbiter_control.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the arbiter control testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_cu_arbiter_control
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f compile.f -o "$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim/tb_cu_arbiter_control.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cu_arbiter_control;

	import cu_bus_pkg::*;
	import cu_arbiter_cfg_pkg::*;

	localparam int NUM_CU       = 4;
	localparam int PERIOD_NS    = 8;
	localparam int RESET_CYCLES = 3;
	localparam int T_DISABLED   = 40;
	localparam int T_RANDOM     = 400;
	localparam int T_SETTLE     = 8;
	localparam int T_FAIR       = 200;
	localparam int T_FILL       = 20;
	localparam int T_HOLD       = 60;
	localparam int T_RESUME     = 200;
	localparam int DRAIN_MARGIN = 300;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + T_DISABLED + T_RANDOM + T_SETTLE
		+ T_FAIR + T_FILL + T_HOLD + T_RESUME + DRAIN_MARGIN;

	logic                     clock;
	logic                     rstn;
	logic                     enabled_in;
	logic        [NUM_CU-1:0] cmd_valid;
	command_t    [NUM_CU-1:0] cmd;
	done_count_t [NUM_CU-1:0] done_count;
	logic                     mem_cmd_grant;
	logic                     resp_valid;
	response_t                resp;
	logic        [NUM_CU-1:0] cmd_grant;
	logic                     mem_cmd_request;
	logic                     mem_cmd_valid;
	command_t                 mem_cmd;
	logic        [NUM_CU-1:0] resp_cu_valid;
	response_t                resp_cu;
	done_count_t              done_total;

	// Stimulus modes that the sequence changes on a clock edge
	logic enable_on;
	logic unit_on;
	logic hold_all;
	logic resp_on;
	logic done_on;
	int   mem_mode;    // 0 withheld, 1 random, 2 every cycle
	logic quiet_check;
	logic stall_check;
	logic fair_check;

	// Reference state
	logic [31:0]       lfsr_state;
	command_t          exp_q [NUM_CU][$];
	int unsigned       seq [NUM_CU];
	int                since_grant [NUM_CU][NUM_CU];
	logic [NUM_CU-1:0] granted_once;
	int                outstanding;
	int                error_count;
	int                tests_run;
	int                test_errors_start;

	// Expected values two edges behind the inputs
	logic        resp_d1;
	logic        resp_d2;
	response_t   resp_val_d1;
	response_t   resp_val_d2;
	done_count_t sum_d1;
	done_count_t sum_d2;
	logic        en_d1;
	logic        en_d2;

	cu_arbiter_control #(.NUM_CU(NUM_CU)) i_cu_arbiter_control (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.cmd_valid      (cmd_valid),
		.cmd            (cmd),
		.done_count     (done_count),
		.mem_cmd_grant  (mem_cmd_grant),
		.resp_valid     (resp_valid),
		.resp           (resp),
		.cmd_grant      (cmd_grant),
		.mem_cmd_request(mem_cmd_request),
		.mem_cmd_valid  (mem_cmd_valid),
		.mem_cmd        (mem_cmd),
		.resp_cu_valid  (resp_cu_valid),
		.resp_cu        (resp_cu),
		.done_total     (done_total)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value      = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [NUM_CU-1:0] unit_onehot(input cu_id_t id);
		logic [NUM_CU-1:0] hot;
		for (int k = 0; k < NUM_CU; k++) begin
			hot[k] = (int'(id) == k);
		end
		return hot;
	endfunction

	// Exact sum in 64 bits reduced modulo 2^32
	function automatic done_count_t sum_counts(input done_count_t [NUM_CU-1:0] counts);
		logic [63:0] total;
		total = '0;
		for (int k = 0; k < NUM_CU; k++) begin
			total = total + 64'(counts[k]);
		end
		return done_count_t'(total % 64'h1_0000_0000);
	endfunction

	// Unit id on top and sequence number at the bottom
	task automatic present_command(input int u);
		cmd[u]       = {cu_id_t'(u), 16'(rand_bits(16)), 20'(seq[u])};
		cmd_valid[u] = 1'b1;
		seq[u]++;
	endtask

	task automatic note_grant(input int w);
		logic fair;
		fair = 1'b1;
		for (int v = 0; v < NUM_CU; v++) begin
			if (v != w && granted_once[w] && since_grant[w][v] != 1) begin
				fair = 1'b0;
			end
		end
		assert (fair) else begin
			error_count++;
			$display("mismatch at %0t: unit %0d granted again before each other unit had one grant",
				$time, w);
		end
		for (int v = 0; v < NUM_CU; v++) begin
			since_grant[w][v] = 0;
		end
		granted_once[w] = 1'b1;
		for (int u = 0; u < NUM_CU; u++) begin
			if (u != w) begin
				since_grant[u][w]++;
			end
		end
	endtask

	task automatic step_units();
		for (int u = 0; u < NUM_CU; u++) begin
			if (cmd_grant[u]) begin
				exp_q[u].push_back(cmd[u]);
				outstanding++;
				if (fair_check) begin
					note_grant(u);
				end
				if (unit_on && (hold_all || rand_bits(1) != 0)) begin
					present_command(u);
				end else begin
					cmd_valid[u] = 1'b0;
				end
			end else if (unit_on && !cmd_valid[u] && (hold_all || rand_bits(2) == 0)) begin
				present_command(u);
			end
		end
	endtask

	task automatic check_delivery();
		int id;
		if (mem_cmd_valid) begin
			id = int'(mem_cmd[CMD_BITS-1 -: CU_ID_BITS]);
			outstanding--;
			assert (id < NUM_CU && exp_q[id].size() > 0) else begin
				error_count++;
				$display("command %h reached memory at %0t but its unit has nothing pending",
					mem_cmd, $time);
			end
			if (id < NUM_CU && exp_q[id].size() > 0) begin
				assert (mem_cmd == exp_q[id][0]) else begin
					error_count++;
					$display("mismatch at %0t: memory command %h, expected %h from unit %0d",
						$time, mem_cmd, exp_q[id][0], id);
				end
				void'(exp_q[id].pop_front());
			end
		end
		assert (outstanding <= CMD_FIFO_DEPTH) else begin
			error_count++;
			$display("burst buffer holds %0d commands at %0t, more than its %0d entries",
				outstanding, $time, CMD_FIFO_DEPTH);
		end
	endtask

	task automatic drive_inputs();
		enabled_in = enable_on;
		case (mem_mode)
			1:       mem_cmd_grant = (rand_bits(1) != 0);
			2:       mem_cmd_grant = 1'b1;
			default: mem_cmd_grant = 1'b0;
		endcase
		resp_valid = 1'b0;
		if (resp_on && rand_bits(2) == 0) begin
			resp_valid = 1'b1;
			resp       = {cu_id_t'(rand_bits(CU_ID_BITS) % NUM_CU), 12'(rand_bits(12))};
		end
		if (done_on) begin
			for (int k = 0; k < NUM_CU; k++) begin
				if (rand_bits(1) != 0) begin
					done_count[k] = rand_bits(32);
				end
			end
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("test %0d (%s) finished with %0d errors", tests_run, name,
			error_count - test_errors_start);
		test_errors_start = error_count;
	endtask

	////////////////////////////////////////
	// Clock, unit and memory models
	////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clock = ~clock;
		end
	end

	// Everything the DUT sees changes 1 ns after the edge
	initial begin
		lfsr_state    = 32'h34b0_59ef;
		enabled_in    = 1'b0;
		cmd_valid     = '0;
		cmd           = '0;
		done_count    = '0;
		mem_cmd_grant = 1'b0;
		resp_valid    = 1'b0;
		resp          = '0;
		for (int u = 0; u < NUM_CU; u++) begin
			seq[u] = 0;
		end
		forever begin
			@(posedge clock);
			#1;
			step_units();
			check_delivery();
			drive_inputs();
		end
	end

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_d1     <= 1'b0;
			resp_d2     <= 1'b0;
			resp_val_d1 <= '0;
			resp_val_d2 <= '0;
			sum_d1      <= '0;
			sum_d2      <= '0;
			en_d1       <= 1'b0;
			en_d2       <= 1'b0;
		end else begin
			resp_d1     <= resp_valid;
			resp_d2     <= resp_d1;
			resp_val_d1 <= resp;
			resp_val_d2 <= resp_val_d1;
			sum_d1      <= sum_counts(done_count);
			sum_d2      <= sum_d1;
			en_d1       <= enabled_in;
			en_d2       <= en_d1;
		end
	end

	////////////////////////////////////////
	// Checks on the DUT outputs
	////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstn)
		quiet_check |-> (cmd_grant == '0 && !mem_cmd_request && !mem_cmd_valid
			&& resp_cu_valid == '0))
		else begin
			error_count++;
			$display("mismatch at %0t: command or response activity while disabled", $time);
		end

	assert property (@(posedge clock) disable iff (!rstn) $onehot0(cmd_grant))
		else begin
			error_count++;
			$display("mismatch at %0t: cmd_grant %b has more than one bit set",
				$time, $sampled(cmd_grant));
		end

	assert property (@(posedge clock) disable iff (!rstn)
		resp_cu_valid == (resp_d2 ? unit_onehot(resp_val_d2[RESP_BITS-1 -: CU_ID_BITS]) : '0))
		else begin
			error_count++;
			$display("mismatch at %0t: resp_cu_valid %b, expected %0d cycles after response %h",
				$time, $sampled(resp_cu_valid), 2, $sampled(resp_val_d2));
		end

	assert property (@(posedge clock) disable iff (!rstn) resp_d2 |-> resp_cu == resp_val_d2)
		else begin
			error_count++;
			$display("mismatch at %0t: resp_cu %h, expected %h",
				$time, $sampled(resp_cu), $sampled(resp_val_d2));
		end

	assert property (@(posedge clock) disable iff (!rstn) en_d2 |-> done_total == sum_d2)
		else begin
			error_count++;
			$display("mismatch at %0t: done_total %h, expected %h",
				$time, $sampled(done_total), $sampled(sum_d2));
		end

	// With memory withheld the request holds and the arbiter stays throttled
	assert property (@(posedge clock) disable iff (!rstn)
		stall_check |-> (mem_cmd_request && cmd_grant == '0))
		else begin
			error_count++;
			$display("mismatch at %0t: request %b grant %b while memory grants are withheld",
				$time, $sampled(mem_cmd_request), $sampled(cmd_grant));
		end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		rstn              = 1'b0;
		enable_on         = 1'b0;
		unit_on           = 1'b0;
		hold_all          = 1'b0;
		resp_on           = 1'b0;
		done_on           = 1'b0;
		mem_mode          = 0;
		quiet_check       = 1'b1;
		stall_check       = 1'b0;
		fair_check        = 1'b0;
		granted_once      = '0;
		outstanding       = 0;
		error_count       = 0;
		tests_run         = 0;
		test_errors_start = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(posedge clock);

		// Units and memory active while the block is disabled
		unit_on  = 1'b1;
		mem_mode = 1;
		repeat (T_DISABLED) @(posedge clock);
		quiet_check = 1'b0;
		report_test("idle while disabled");

		enable_on = 1'b1;
		resp_on   = 1'b1;
		done_on   = 1'b1;
		repeat (T_RANDOM) @(posedge clock);
		report_test("random traffic");

		hold_all = 1'b1;
		repeat (T_SETTLE) @(posedge clock);
		for (int u = 0; u < NUM_CU; u++) begin
			for (int v = 0; v < NUM_CU; v++) begin
				since_grant[u][v] = 0;
			end
		end
		granted_once = '0;
		fair_check   = 1'b1;
		repeat (T_FAIR) @(posedge clock);
		fair_check = 1'b0;
		report_test("round-robin fairness");

		mem_mode = 0;
		repeat (T_FILL) @(posedge clock);
		stall_check = 1'b1;
		repeat (T_HOLD) @(posedge clock);
		stall_check = 1'b0;
		mem_mode    = 1;
		repeat (T_RESUME) @(posedge clock);
		report_test("memory back-pressure");

		// No new commands while memory takes one per cycle until empty
		unit_on  = 1'b0;
		hold_all = 1'b0;
		resp_on  = 1'b0;
		mem_mode = 2;
		while (outstanding != 0 || cmd_valid != '0) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		for (int u = 0; u < NUM_CU; u++) begin
			assert (exp_q[u].size() == 0) else begin
				error_count++;
				$display("unit %0d still has %0d granted commands that never reached memory",
					u, exp_q[u].size());
			end
		end
		report_test("drain");

		$display("%0d tests run, %0d checks failed", tests_run, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD_NS);
		$display("timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/cu_arbiter_control.sv
`timescale 1ns/100ps
`default_nettype none

module cu_arbiter_control #(
	parameter int NUM_CU = cu_arbiter_cfg_pkg::NUM_CU_DEFAULT
) (
	input  wire logic                                 clock,
	input  wire logic                                 rstn,
	input  wire logic                                 enabled_in,
	input  wire logic                    [NUM_CU-1:0] cmd_valid,
	input  wire cu_bus_pkg::command_t    [NUM_CU-1:0] cmd,
	input  wire cu_bus_pkg::done_count_t [NUM_CU-1:0] done_count,
	input  wire logic                                 mem_cmd_grant,
	input  wire logic                                 resp_valid,
	input  wire cu_bus_pkg::response_t                resp,
	output logic                         [NUM_CU-1:0] cmd_grant,
	output logic                                      mem_cmd_request,
	output logic                                      mem_cmd_valid,
	output cu_bus_pkg::command_t                      mem_cmd,
	output logic                         [NUM_CU-1:0] resp_cu_valid,
	output cu_bus_pkg::response_t                     resp_cu,
	output cu_bus_pkg::done_count_t                   done_total
);

	import cu_bus_pkg::*;
	import cu_arbiter_cfg_pkg::*;

	logic                     enabled;
	logic        [NUM_CU-1:0] cmd_valid_q;
	command_t    [NUM_CU-1:0] cmd_q;
	done_count_t [NUM_CU-1:0] done_count_q;
	logic                     push;
	command_t                 push_cmd;
	logic                     fifo_alfull;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	cu_command_capture #(.NUM_CU(NUM_CU)) i_cu_command_capture (
		.clock       (clock),
		.rstn        (rstn),
		.enabled_in  (enabled_in),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.done_count  (done_count),
		.enabled     (enabled),
		.cmd_valid_q (cmd_valid_q),
		.cmd_q       (cmd_q),
		.done_count_q(done_count_q)
	);

	////////////////////////////////////////
	// Read command path
	////////////////////////////////////////

	command_rr_arbiter #(.NUM_CU(NUM_CU)) i_command_rr_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.cmd_valid_q(cmd_valid_q),
		.cmd_q      (cmd_q),
		.fifo_alfull(fifo_alfull),
		.cmd_grant  (cmd_grant),
		.push       (push),
		.push_cmd   (push_cmd)
	);

	command_burst_fifo #(.DEPTH(CMD_FIFO_DEPTH)) i_command_burst_fifo (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.push           (push),
		.push_cmd       (push_cmd),
		.mem_cmd_grant  (mem_cmd_grant),
		.fifo_alfull    (fifo_alfull),
		.mem_cmd_request(mem_cmd_request),
		.mem_cmd_valid  (mem_cmd_valid),
		.mem_cmd        (mem_cmd)
	);

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////

	response_router #(.NUM_CU(NUM_CU)) i_response_router (
		.clock        (clock),
		.rstn         (rstn),
		.resp_valid   (resp_valid),
		.resp         (resp),
		.resp_cu_valid(resp_cu_valid),
		.resp_cu      (resp_cu)
	);

	done_count_reduce #(.NUM_CU(NUM_CU)) i_done_count_reduce (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.done_count_q(done_count_q),
		.done_total  (done_total)
	);

endmodule

`default_nettype wire

// File: hdl/done_count_reduce.sv
`timescale 1ns/100ps
`default_nettype none

module done_count_reduce #(
	parameter int NUM_CU = 1
) (
	input  wire logic                                 clock,
	input  wire logic                                 rstn,
	input  wire logic                                 enabled,
	input  wire cu_bus_pkg::done_count_t [NUM_CU-1:0] done_count_q,
	output cu_bus_pkg::done_count_t                   done_total
);

	import cu_bus_pkg::*;

	done_count_t sum;

	////////////////////////////////////////
	// Adder tree
	////////////////////////////////////////

	// Plain 32-bit adds, overflow wraps
	always_comb begin
		sum = '0;
		for (int k = 0; k < NUM_CU; k++) begin
			sum = sum + done_count_q[k];
		end
	end

	////////////////////////////////////////
	// Total register
	////////////////////////////////////////

	// Frozen while the block is disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done_total <= '0;
		end else if (enabled) begin
			done_total <= sum;
		end
	end

endmodule

`default_nettype wire

// File: hdl/response_router.sv
`timescale 1ns/100ps
`default_nettype none

module response_router #(
	parameter int NUM_CU = 1
) (
	input  wire logic                  clock,
	input  wire logic                  rstn,
	input  wire logic                  resp_valid,
	input  wire cu_bus_pkg::response_t resp,
	output logic          [NUM_CU-1:0] resp_cu_valid,
	output cu_bus_pkg::response_t      resp_cu
);

	import cu_bus_pkg::*;

	logic      resp_valid_q;
	response_t resp_q;
	cu_id_t    resp_id;

	// Unit id sits in the top bits of the response
	assign resp_id = resp_q[$bits(response_t)-1 -: CU_ID_BITS];

	////////////////////////////////////////
	// Input stage
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= resp_valid;
		end
	end

	always_ff @(posedge clock) begin
		resp_q <= resp;
	end

	////////////////////////////////////////
	// Decode and output stage
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_cu_valid <= '0;
		end else begin
			for (int k = 0; k < NUM_CU; k++) begin
				resp_cu_valid[k] <= resp_valid_q && (resp_id == cu_id_t'(k));
			end
		end
	end

	// Shared payload to all units
	always_ff @(posedge clock) begin
		resp_cu <= resp_q;
	end

	// Memory side must only answer units that exist
	assert property (@(posedge clock) disable iff (!rstn) resp_valid_q |-> int'(resp_id) < NUM_CU)
		else $error("response addressed to a unit id outside the configured range");

endmodule

`default_nettype wire

// File: hdl/command_burst_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module command_burst_fifo #(
	parameter int DEPTH = cu_arbiter_cfg_pkg::CMD_FIFO_DEPTH
) (
	input  wire logic                 clock,
	input  wire logic                 rstn,
	input  wire logic                 enabled,
	input  wire logic                 push,
	input  wire cu_bus_pkg::command_t push_cmd,
	input  wire logic                 mem_cmd_grant,
	output logic                      fifo_alfull,
	output logic                      mem_cmd_request,
	output logic                      mem_cmd_valid,
	output cu_bus_pkg::command_t      mem_cmd
);

	import cu_bus_pkg::*;
	import cu_arbiter_cfg_pkg::*;

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	command_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                full;
	logic                empty;
	logic                wr_en;
	logic                rd_en;

	// Circular pointer step, depth need not be a power of two
	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	////////////////////////////////////////
	// Status
	////////////////////////////////////////

	assign empty       = (count == '0);
	assign full        = (count == CNT_BITS'(DEPTH));
	assign fifo_alfull = (CNT_BITS'(DEPTH) - count) <= CNT_BITS'(CMD_FIFO_ALFULL_MARGIN);

	assign mem_cmd_request = enabled && !empty;

	assign wr_en = push && !full;
	// Grant counts only while the request is up
	assign rd_en = mem_cmd_grant && mem_cmd_request;

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			mem_cmd_valid <= 1'b0;
		end else begin
			mem_cmd_valid <= rd_en;
			if (wr_en) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and head register
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_cmd;
		end
		if (rd_en) begin
			mem_cmd <= mem[rd_ptr];
		end
	end

	// Arbiter throttling must keep the buffer from overflowing
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("command pushed into a full burst buffer");

endmodule

`default_nettype wire

// File: hdl/command_rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module command_rr_arbiter #(
	parameter int NUM_CU = 1
) (
	input  wire logic                              clock,
	input  wire logic                              rstn,
	input  wire logic                              enabled,
	input  wire logic                 [NUM_CU-1:0] cmd_valid_q,
	input  wire cu_bus_pkg::command_t [NUM_CU-1:0] cmd_q,
	input  wire logic                              fifo_alfull,
	output logic                      [NUM_CU-1:0] cmd_grant,
	output logic                                   push,
	output cu_bus_pkg::command_t                   push_cmd
);

	import cu_bus_pkg::*;

	cu_id_t            last_winner;
	cu_id_t            winner;
	logic              found;
	logic              can_grant;
	logic [NUM_CU-1:0] requests;
	logic [NUM_CU-1:0] grant_onehot;

	// Mask the last winner whose captured valid is one cycle stale
	assign requests = cmd_valid_q & ~cmd_grant;

	////////////////////////////////////////
	// Round-robin search
	////////////////////////////////////////

	// First requester after the last winner with wrap-around
	always_comb begin
		int idx;
		found        = 1'b0;
		winner       = last_winner;
		grant_onehot = '0;
		for (int off = 1; off <= NUM_CU; off++) begin
			idx = (int'(last_winner) + off) % NUM_CU;
			if (!found && requests[idx]) begin
				found             = 1'b1;
				winner            = cu_id_t'(idx);
				grant_onehot[idx] = 1'b1;
			end
		end
	end

	assign can_grant = enabled && !fifo_alfull && found;

	////////////////////////////////////////
	// Grant, push and pointer
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_grant   <= '0;
			push        <= 1'b0;
			// Unit 0 has first priority after reset
			last_winner <= cu_id_t'(NUM_CU - 1);
		end else begin
			cmd_grant <= can_grant ? grant_onehot : '0;
			push      <= can_grant;
			if (can_grant) begin
				last_winner <= winner;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (can_grant) begin
			push_cmd <= cmd_q[winner];
		end
	end

	// At most one unit granted per cycle
	assert property (@(posedge clock) disable iff (!rstn) $onehot0(cmd_grant))
		else $error("more than one unit granted in the same cycle");

endmodule

`default_nettype wire

// File: hdl/cu_command_capture.sv
`timescale 1ns/100ps
`default_nettype none

module cu_command_capture #(
	parameter int NUM_CU = 1
) (
	input  wire logic                                   clock,
	input  wire logic                                   rstn,
	input  wire logic                                   enabled_in,
	input  wire logic                      [NUM_CU-1:0] cmd_valid,
	input  wire cu_bus_pkg::command_t      [NUM_CU-1:0] cmd,
	input  wire cu_bus_pkg::done_count_t   [NUM_CU-1:0] done_count,
	output logic                                        enabled,
	output logic                           [NUM_CU-1:0] cmd_valid_q,
	output cu_bus_pkg::command_t           [NUM_CU-1:0] cmd_q,
	output cu_bus_pkg::done_count_t        [NUM_CU-1:0] done_count_q
);

	import cu_bus_pkg::*;

	////////////////////////////////////////
	// Control and count registers
	////////////////////////////////////////

	// Enable level goes through one register only
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// Per-unit valids and done counts
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid_q  <= '0;
			done_count_q <= '0;
		end else begin
			cmd_valid_q  <= cmd_valid;
			done_count_q <= done_count;
		end
	end

	////////////////////////////////////////
	// Command payloads
	////////////////////////////////////////

	// Copy of each unit command
	always_ff @(posedge clock) begin
		cmd_q <= cmd;
	end

endmodule

`default_nettype wire

// File: hdl/cu_arbiter_cfg_pkg.sv
`default_nettype none

package cu_arbiter_cfg_pkg;

	////////////////////////////////////////
	// Build configuration
	////////////////////////////////////////

	// Default number of compute units, at most 16 (4-bit unit id)
	localparam int NUM_CU_DEFAULT = 4;

	// Burst buffer entries
	localparam int CMD_FIFO_DEPTH = 8;

	// Free entries at or below which the buffer reports almost full
	// Leaves room for the one command the arbiter may have in flight
	localparam int CMD_FIFO_ALFULL_MARGIN = 2;

endpackage

`default_nettype wire

// File: hdl/cu_bus_pkg.sv
`default_nettype none

package cu_bus_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	// Unit id leads every command and response
	localparam int CU_ID_BITS = 4;

	localparam int CMD_BITS        = 40;
	localparam int RESP_BITS       = 16;
	localparam int DONE_COUNT_BITS = 32;

	////////////////////////////////////////
	// Bus formats
	////////////////////////////////////////

	// Read command
	// [39:36] issuing unit id, [35:0] address and tag
	typedef logic [CMD_BITS-1:0] command_t;

	// Memory response
	// [15:12] unit id, [11:0] tag and status
	typedef logic [RESP_BITS-1:0] response_t;

	// Processed vertex count, sums wrap modulo 2^32
	typedef logic [DONE_COUNT_BITS-1:0] done_count_t;

	// Unit index
	typedef logic [CU_ID_BITS-1:0] cu_id_t;

endpackage

`default_nettype wire
